//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_e op,
  input  logic [7:0]       a,   // field A register
  input  logic [7:0]       b,   // field B register
  input  logic [1:0]       imm,
  output logic [7:0]       res
);

  logic [2:0] shamt;

  assign shamt = b[2:0]; // only low three bits shift

  always_comb begin
    case (op)
      cpu_pkg::ALU_MOVE: res = b;
      cpu_pkg::ALU_ADD:  res = a + b;  // wraps mod 256
      cpu_pkg::ALU_AND:  res = a & b;
      cpu_pkg::ALU_NOT:  res = ~b;
      cpu_pkg::ALU_NOR:  res = ~(a | b);
      cpu_pkg::ALU_SLT: begin
        // unsigned compare
        res = (a < b) ? 8'd1 : 8'd0;
      end
      cpu_pkg::ALU_SLL:  res = a << shamt;
      cpu_pkg::ALU_SRL:  res = a >> shamt; // logical, zero fill
      cpu_pkg::ALU_ADDI: res = a + {6'd0, imm};
      default:           res = b;          // unused codes behave as move
    endcase
  end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic [7:0]     instr,
  output cpu_pkg::ctrl_t ctrl
);

  cpu_pkg::opcode_e opcode;

  assign opcode = cpu_pkg::opcode_e'(instr[7:4]);

  always_comb begin
    // register fields never depend on the opcode
    ctrl.ra        = instr[3:2];
    ctrl.rb        = instr[1:0];
    ctrl.imm       = instr[1:0];
    ctrl.alu_op    = cpu_pkg::ALU_MOVE;
    ctrl.wb_src    = cpu_pkg::WB_ALU;
    ctrl.reg_we    = 1'b0;
    ctrl.mem_we    = 1'b0;
    ctrl.rd        = instr[3:2]; // field A unless noted
    ctrl.jump      = 1'b0;
    ctrl.branch_eq = 1'b0;
    ctrl.branch_ne = 1'b0;

    case (opcode)
      cpu_pkg::OP_MOVE: begin
        ctrl.reg_we = 1'b1; // A = B
      end
      cpu_pkg::OP_ADD: begin
        ctrl.alu_op = cpu_pkg::ALU_ADD;
        ctrl.reg_we = 1'b1;
        ctrl.rd     = 2'd0; // result lands in r0
      end
      cpu_pkg::OP_AND: begin
        ctrl.alu_op = cpu_pkg::ALU_AND;
        ctrl.reg_we = 1'b1;
        ctrl.rd     = 2'd0;
      end
      cpu_pkg::OP_NOT: begin
        ctrl.alu_op = cpu_pkg::ALU_NOT;
        ctrl.reg_we = 1'b1;
      end
      cpu_pkg::OP_NOR: begin
        ctrl.alu_op = cpu_pkg::ALU_NOR;
        ctrl.reg_we = 1'b1;
        ctrl.rd     = 2'd0;
      end
      cpu_pkg::OP_SLT: begin
        ctrl.alu_op = cpu_pkg::ALU_SLT;
        ctrl.reg_we = 1'b1;
        ctrl.rd     = 2'd0;
      end
      cpu_pkg::OP_SLL: begin
        ctrl.alu_op = cpu_pkg::ALU_SLL;
        ctrl.reg_we = 1'b1;
      end
      cpu_pkg::OP_SRL: begin
        ctrl.alu_op = cpu_pkg::ALU_SRL;
        ctrl.reg_we = 1'b1;
      end
      cpu_pkg::OP_J: ctrl.jump = 1'b1; // target is reg B
      cpu_pkg::OP_JAL: begin
        ctrl.jump   = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.rd     = 2'd3;           // link register
        ctrl.wb_src = cpu_pkg::WB_LINK;
      end
      cpu_pkg::OP_LW: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_src = cpu_pkg::WB_MEM;
      end
      cpu_pkg::OP_SW: ctrl.mem_we = 1'b1; // mem[B] = A
      cpu_pkg::OP_BEQ: begin
        ctrl.branch_eq = 1'b1;
      end
      cpu_pkg::OP_BNE: begin
        ctrl.branch_ne = 1'b1;
      end
      cpu_pkg::OP_ADDI: begin
        ctrl.alu_op = cpu_pkg::ALU_ADDI;
        ctrl.reg_we = 1'b1;
      end
      cpu_pkg::OP_LI: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_src = cpu_pkg::WB_IMM; // zero-extended imm
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 8; // data and address width

  // opcode sits in instr[7:4]
  typedef enum logic [3:0] {
    OP_MOVE = 4'h0,
    OP_ADD  = 4'h1,
    OP_AND  = 4'h2,
    OP_NOT  = 4'h3,
    OP_NOR  = 4'h4,
    OP_SLT  = 4'h5,
    OP_SLL  = 4'h6,
    OP_SRL  = 4'h7,
    OP_J    = 4'h8,
    OP_JAL  = 4'h9,
    OP_LW   = 4'ha,
    OP_SW   = 4'hb,
    OP_BEQ  = 4'hc,
    OP_BNE  = 4'hd,
    OP_ADDI = 4'he,
    OP_LI   = 4'hf
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_MOVE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_NOT  = 4'd3,
    ALU_NOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLL  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_ADDI = 4'd8
  } alu_op_e;

  // write-back source select
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_IMM  = 2'd2,
    WB_LINK = 2'd3  // pc+1, jal only
  } wb_src_e;

  typedef struct packed {
    alu_op_e    alu_op;
    wb_src_e    wb_src;
    logic       reg_we;
    logic       mem_we;
    logic [1:0] rd;   // write register
    logic [1:0] ra;   // field A, instr[3:2]
    logic [1:0] rb;   // field B, instr[1:0]
    logic [1:0] imm;  // same bits as rb
    logic       jump;
    logic       branch_eq;
    logic       branch_ne;
  } ctrl_t;

  // one executed instruction
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            reg_we;
    logic [1:0]      reg_addr;
    logic [XLEN-1:0] reg_data;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;  // full byte, memory decodes low bits
    logic [XLEN-1:0] mem_data;
    logic [XLEN-1:0] next_pc;
  } retire_t;

endpackage

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int DMEM_ADDR_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  output logic [7:0]       imem_addr,
  input  logic [7:0]       instr,       // comb return of imem_addr
  output logic             retire_valid,
  output cpu_pkg::retire_t retire
);

  cpu_pkg::ctrl_t             ctrl;
  logic [7:0]                 ra_data, rb_data, r0_data;
  logic [7:0]                 alu_res;
  logic [7:0]                 mem_rdata;
  logic [7:0]                 pc, next_pc;
  logic [cpu_pkg::XLEN-1:0]   wb_data;
  logic                       reg_we, mem_we;

  assign imem_addr = pc;

  // no writes while reset is held
  assign reg_we = ctrl.reg_we & rst_n;
  assign mem_we = ctrl.mem_we & rst_n;

  control_unit u_ctrl (.instr(instr), .ctrl(ctrl));

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n),
    .ra(ctrl.ra), .rb(ctrl.rb),
    .we(reg_we), .wa(ctrl.rd), .wd(wb_data),
    .ra_data(ra_data), .rb_data(rb_data), .r0_data(r0_data)
  );

  alu u_alu (.op(ctrl.alu_op), .a(ra_data), .b(rb_data), .imm(ctrl.imm), .res(alu_res));

  pc_unit u_pc (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl),
    .a_data(ra_data), .b_data(rb_data), .r0_data(r0_data),
    .pc(pc), .next_pc(next_pc)
  );

  // address from reg B, store data from reg A
  data_mem #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_dmem (
    .clk(clk), .rst_n(rst_n),
    .addr(rb_data), .we(mem_we), .wdata(ra_data), .rdata(mem_rdata)
  );

  always_comb begin
    case (ctrl.wb_src)
      cpu_pkg::WB_ALU:  wb_data = alu_res;
      cpu_pkg::WB_MEM:  wb_data = mem_rdata;
      cpu_pkg::WB_IMM:  wb_data = {6'd0, ctrl.imm};
      cpu_pkg::WB_LINK: wb_data = pc + 8'd1; // return address for jal
      default:          wb_data = alu_res;
    endcase
  end

  // trace of the instruction that commits at the coming edge
  assign retire_valid = rst_n;

  always_comb begin
    retire.pc       = pc;
    retire.reg_we   = reg_we;
    retire.reg_addr = ctrl.rd;
    retire.reg_data = wb_data;
    retire.mem_we   = mem_we;
    retire.mem_addr = rb_data;
    retire.mem_data = ra_data;
    retire.next_pc  = next_pc;
  end

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int DMEM_ADDR_W = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] addr,
  input  logic       we,
  input  logic [7:0] wdata,
  output logic [7:0] rdata
);

  localparam int DEPTH = 1 << DMEM_ADDR_W;

  logic [7:0]             mem [DEPTH];
  logic [DMEM_ADDR_W-1:0] idx;

  assign idx   = addr[DMEM_ADDR_W-1:0]; // upper address bits ignored
  assign rdata = mem[idx];              // async read for lw

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[idx] <= wdata;
    end
  end

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::ctrl_t ctrl,
  input  logic [7:0]     a_data,
  input  logic [7:0]     b_data,
  input  logic [7:0]     r0_data,
  output logic [7:0]     pc,
  output logic [7:0]     next_pc
);

  logic eq;     // A == B
  logic taken;  // branch goes to r0

  assign eq    = (a_data == b_data);
  assign taken = (ctrl.branch_eq & eq) | (ctrl.branch_ne & ~eq);

  always_comb begin
    if (ctrl.jump) begin
      next_pc = b_data;       // j and jal
    end else if (taken) begin
      next_pc = r0_data;
    end else begin
      next_pc = pc + 8'd1;    // wraps at 256
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] ra,
  input  logic [1:0] rb,
  input  logic       we,
  input  logic [1:0] wa,
  input  logic [7:0] wd,
  output logic [7:0] ra_data,
  output logic [7:0] rb_data,
  output logic [7:0] r0_data
);

  logic [7:0] regs [4]; // r0..r3

  // async reads
  assign ra_data = regs[ra];
  assign rb_data = regs[rb];
  assign r0_data = regs[0]; // branch target source

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds cpu_tb with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module cpu_tb -Mdir obj_dir -f sources.f \
  && ./obj_dir/Vcpu_tb | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 4;
  localparam int N_INSTR        = 3000;
  localparam int TIMEOUT_CYCLES = N_INSTR + RESET_CYCLES + 100;
  localparam int DMEM_ADDR_W    = 4;
  localparam int DMEM_DEPTH     = 1 << DMEM_ADDR_W;

  logic             clk;
  logic             rst_n;
  logic [7:0]       imem_addr;
  logic [7:0]       instr;
  logic             retire_valid;
  cpu_pkg::retire_t retire;

  logic [7:0] imem [256];              // random program
  logic [7:0] model_regs [4];          // ISA model state
  logic [7:0] model_mem [DMEM_DEPTH];
  logic [7:0] model_pc;
  int         op_count [16];
  int         retired;
  int         cycle_count;

  cpu_top #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .imem_addr(imem_addr), .instr(instr),
    .retire_valid(retire_valid), .retire(retire)
  );

  assign instr = imem[imem_addr]; // comb fetch in the same cycle

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
    abort_run($sformatf("ERROR at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp));
  endtask

  task automatic check_pc(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_reg_write(input cpu_pkg::retire_t got, input cpu_pkg::retire_t exp);
    if (got.reg_we !== exp.reg_we) begin
      report_mismatch("retire.reg_we", {7'd0, got.reg_we}, {7'd0, exp.reg_we});
    end
    // address and data only mean something with the enable set
    if (exp.reg_we) begin
      if (got.reg_addr !== exp.reg_addr) begin
        report_mismatch("retire.reg_addr", {6'd0, got.reg_addr}, {6'd0, exp.reg_addr});
      end
      if (got.reg_data !== exp.reg_data) report_mismatch("retire.reg_data", got.reg_data,
                                                         exp.reg_data);
    end
  endtask

  task automatic check_mem_write(input cpu_pkg::retire_t got, input cpu_pkg::retire_t exp);
    if (got.mem_we !== exp.mem_we) begin
      report_mismatch("retire.mem_we", {7'd0, got.mem_we}, {7'd0, exp.mem_we});
    end
    if (exp.mem_we) begin
      if (got.mem_addr !== exp.mem_addr) report_mismatch("retire.mem_addr", got.mem_addr,
                                                         exp.mem_addr);
      if (got.mem_data !== exp.mem_data) report_mismatch("retire.mem_data", got.mem_data,
                                                         exp.mem_data);
    end
  endtask

  // expected trace of one instruction from the ISA rules
  function automatic cpu_pkg::retire_t predict(input logic [7:0] ins);
    cpu_pkg::retire_t exp;
    logic [1:0]       fa;
    logic [1:0]       fb;
    logic [7:0]       va;
    logic [7:0]       vb;
    fa = ins[3:2];
    fb = ins[1:0];
    va = model_regs[fa];
    vb = model_regs[fb];
    exp          = '0;
    exp.pc       = model_pc;
    exp.next_pc  = model_pc + 8'd1;
    exp.reg_we   = 1'b1;            // most opcodes write field A
    exp.reg_addr = fa;
    exp.mem_addr = vb;
    exp.mem_data = va;
    case (cpu_pkg::opcode_e'(ins[7:4]))
      cpu_pkg::OP_MOVE: exp.reg_data = vb;
      cpu_pkg::OP_ADD:  exp.reg_data = va + vb;
      cpu_pkg::OP_AND:  exp.reg_data = va & vb;
      cpu_pkg::OP_NOT:  exp.reg_data = ~vb;
      cpu_pkg::OP_NOR:  exp.reg_data = ~(va | vb);
      cpu_pkg::OP_SLT:  exp.reg_data = (va < vb) ? 8'd1 : 8'd0;
      cpu_pkg::OP_SLL:  exp.reg_data = va << vb[2:0];
      cpu_pkg::OP_SRL:  exp.reg_data = va >> vb[2:0];
      cpu_pkg::OP_J: begin
        exp.reg_we  = 1'b0;
        exp.next_pc = vb;
      end
      cpu_pkg::OP_JAL: begin
        exp.reg_addr = 2'd3;             // link reg
        exp.reg_data = model_pc + 8'd1;
        exp.next_pc  = vb;
      end
      cpu_pkg::OP_LW:   exp.reg_data = model_mem[vb[DMEM_ADDR_W-1:0]];
      cpu_pkg::OP_SW: begin
        exp.reg_we = 1'b0;
        exp.mem_we = 1'b1;
      end
      cpu_pkg::OP_BEQ: begin
        exp.reg_we = 1'b0;
        if (va == vb) exp.next_pc = model_regs[0];
      end
      cpu_pkg::OP_BNE: begin
        exp.reg_we = 1'b0;
        if (va != vb) exp.next_pc = model_regs[0];
      end
      cpu_pkg::OP_ADDI: exp.reg_data = va + {6'd0, fb};
      cpu_pkg::OP_LI:   exp.reg_data = {6'd0, fb};
    endcase
    // three-operand ops land in r0
    if (ins[7:4] inside {4'h1, 4'h2, 4'h4, 4'h5}) exp.reg_addr = 2'd0;
    return exp;
  endfunction

  task automatic commit_model(input cpu_pkg::retire_t exp);
    if (exp.reg_we) model_regs[exp.reg_addr] = exp.reg_data;
    if (exp.mem_we) model_mem[exp.mem_addr[DMEM_ADDR_W-1:0]] = exp.mem_data;
    model_pc = exp.next_pc;
  endtask

  task automatic check_step();
    cpu_pkg::retire_t exp;
    logic [7:0]       ins;
    ins = imem[model_pc];
    exp = predict(ins);
    if (retire_valid !== 1'b1) abort_run("retire_valid was low with reset released");
    check_pc("imem_addr", imem_addr, model_pc);
    check_pc("retire.pc", retire.pc, exp.pc);
    check_reg_write(retire, exp);
    check_mem_write(retire, exp);
    check_pc("retire.next_pc", retire.next_pc, exp.next_pc);
    op_count[ins[7:4]]++;
    commit_model(exp); // after the checks
  endtask

  // hang guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: only %0d of %0d instructions retired in %0d cycles",
                          retired, N_INSTR, cycle_count));
    end
  end

  initial begin
    cpu_pkg::retire_t idle_exp; // no writes while in reset
    idle_exp    = '0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    retired     = 0;
    cycle_count = 0;
    model_pc    = 8'd0;
    void'($urandom(32'hd003_5797)); // single seed for the run
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = 8'($urandom);
    end
    for (int i = 0; i < 4; i++) begin
      model_regs[i[1:0]] = 8'd0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
      model_mem[i[DMEM_ADDR_W-1:0]] = 8'd0;
    end
    for (int i = 0; i < 16; i++) begin
      op_count[i] = 0;
    end

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (retire_valid !== 1'b0) abort_run("retire_valid went high while reset was held");
      check_reg_write(retire, idle_exp);
      check_mem_write(retire, idle_exp);
    end
    rst_n = 1'b1; // released on a falling edge

    // sample a quarter period into the low phase where the trace has settled
    while (retired < N_INSTR) begin
      #(CLK_PERIOD/4);
      check_step();
      retired++;
      @(negedge clk);
    end

    $display("retired %0d instructions: %0d lw, %0d sw, %0d beq, %0d bne, %0d jal",
             retired, op_count[10], op_count[11], op_count[12], op_count[13], op_count[9]);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/cpu_pkg.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_unit.sv
hw/data_mem.sv
hw/cpu_top.sv
sim/cpu_tb.sv
